// ==== Bender.yml ====
package:
  name: busSizer

export_include_dirs:
  - include

sources:
  - files:
      - logic/busSizerPkg.sv
      - logic/cycleDecoder.sv
      - logic/laneSteer.sv
      - logic/sizeSequencer.sv
      - logic/busSizerTop.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/busSizerTb.sv

// ==== build.f ====
+incdir+include
+incdir+dv
logic/busSizerPkg.sv
logic/cycleDecoder.sv
logic/laneSteer.sv
logic/sizeSequencer.sv
logic/busSizerTop.sv
dv/busSizerTb.sv

// ==== dv/busSizerChecks.svh ====
// Bus sizing bridge checks
// Strobe protocol assertions and expected lane values from the 68040 sizing rules

`ifndef BUSSIZERCHECKS_SVH
`define BUSSIZERCHECKS_SVH

int errors = 0;

task reportError(input string msg);
    errors++;
    $display("ERROR @ %0t: %s", $time, msg);
    $display("RESULT: FAIL");
    $fatal(1, "check failed");
endtask

////////////////////////////////////////
// Strobe protocol
////////////////////////////////////////

// Termination and port start are single-cycle pulses
assert property (@(posedge BCLK) disable iff (!nRESET) !nTa |=> nTa)
    else reportError("nTa low for more than one cycle");
assert property (@(posedge BCLK) disable iff (!nRESET) !nTeaCpu |=> nTeaCpu)
    else reportError("nTeaCpu low for more than one cycle");
assert property (@(posedge BCLK) disable iff (!nRESET) !nTsPort |=> nTsPort)
    else reportError("nTsPort low for more than one cycle");
// Error replaces TA, never both
assert property (@(posedge BCLK) disable iff (!nRESET) !(!nTa && !nTeaCpu))
    else reportError("nTa and nTeaCpu low together");
assert property (@(posedge BCLK) disable iff (!nRESET) !nTbiCpu |-> !nTa)
    else reportError("nTbiCpu low without nTa");
assert property (@(posedge BCLK) disable iff (!nRESET) !nTciCpu |-> (!nTa || !nTeaCpu))
    else reportError("nTciCpu low outside termination");

////////////////////////////////////////
// Expected values
////////////////////////////////////////

// Operand bytes on the CPU side, siz is the pin code
function logic [31:0] opMask(input logic [1:0] sizCode, input logic [1:0] addr);
    case (sizCode)
        2'b01:   return 32'hFF00_0000 >> (8 * addr); // Byte
        2'b10:   return 32'hFFFF_0000 >> (8 * addr); // Word
        default: return 32'hFFFF_FFFF;               // Long or line
    endcase
endfunction

// CPU read word built from one or two port words
function logic [31:0] expRead(input logic [1:0] sizCode, input logic [1:0] addr,
                              input logic wordPort, input logic [31:0] w0,
                              input logic [31:0] w1);
    if (!wordPort) return w0;                                       // All lanes straight
    if (sizCode == 2'b00 || sizCode == 2'b11) return {w0[31:16], w1[31:16]}; // Two halves
    return addr[1] ? {16'h0, w0[31:16]} : {w0[31:16], 16'h0}; // Addressed half
endfunction

// Lanes the port really takes
function logic [31:0] wrMask(input logic [1:0] sizCode, input logic [1:0] addr,
                             input logic wordPort);
    if (!wordPort) return opMask(sizCode, addr);
    if (sizCode == 2'b01) return addr[0] ? 32'h00FF_0000 : 32'hFF00_0000;
    return 32'hFFFF_0000; // A 16-bit port uses D31:16
endfunction

function logic [31:0] wrExpect(input logic [1:0] sizCode, input logic [1:0] addr,
                               input logic wordPort, input logic second,
                               input logic [31:0] cpu);
    if (!wordPort) return cpu;
    if (sizCode == 2'b00 || sizCode == 2'b11) return second ? {cpu[15:0], 16'h0} : cpu;
    return addr[1] ? {cpu[15:0], 16'h0} : cpu; // Low half moves up
endfunction

`endif

// ==== dv/busSizerTb.sv ====
// Bus sizing bridge testbench
// Drives CPU cycles, answers port starts with a 32 or 16-bit target

`default_nettype none

`include "busSizer_cfg.svh"

module busSizerTb;

    localparam int numTests = 35;

    logic        BCLK = 1'b0;
    logic        nRESET;
    logic        nTsCpu, rnw, nTbi, nTci, nTea, nTsPort;
    logic [1:0]  siz, a, tt, dsack, portAddr;
    logic [31:0] cpuWrData, cpuRdData, portRdData, portWrData;
    logic        nTa, nTbiCpu, nTciCpu, nTeaCpu;
    logic [31:0] lfsrState = 32'd82033;
    int          taCount = 0, teaCount = 0, tsCount = 0, testsRun = 0, ackSeq = 0;

    `include "busSizerChecks.svh"

    always #5 BCLK = !BCLK; // Period 10

    busSizerTop i_busSizerTop (
        .BCLK(BCLK), .nRESET(nRESET), .nTsCpu(nTsCpu), .siz(siz), .a(a), .tt(tt),
        .rnw(rnw), .nTbi(nTbi), .nTci(nTci), .cpuWrData(cpuWrData),
        .cpuRdData(cpuRdData), .nTa(nTa), .nTbiCpu(nTbiCpu), .nTciCpu(nTciCpu),
        .nTeaCpu(nTeaCpu), .dsack(dsack), .nTea(nTea), .portRdData(portRdData),
        .nTsPort(nTsPort), .portWrData(portWrData), .portAddr(portAddr)
    );

    // Pulse counters sample at the falling edge where outputs are stable
    always @(negedge BCLK) begin
        if (nRESET) begin
            if (!nTa) taCount++;
            if (!nTeaCpu) teaCount++;
            if (!nTsPort) tsCount++;
        end
    end

    ////////////////////////////////////////
    // Random source
    ////////////////////////////////////////

    function logic nextBit();
        lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h8020_0003) : (lfsrState >> 1);
        return lfsrState[0];
    endfunction

    function logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) v = {v[30:0], nextBit()}; // One step per bit
        return v;
    endfunction

    task waitCycles(input int n);
        repeat (n) begin
            @(posedge BCLK);
            #1;
        end
    endtask

    ////////////////////////////////////////
    // One CPU cycle with its port target
    ////////////////////////////////////////

    task runCycle(input logic [1:0] sizCode, input logic [1:0] addr, input logic read,
                  input logic wordPort, input logic errAck, input logic ciLow,
                  input logic biLow, input logic extraTs);
        logic        isLine, isLong, term;
        logic [31:0] wr, mask, want;
        logic [31:0] words [0:3];
        int          acks, taBase, teaBase, tsBase, w;
        isLine  = sizCode == 2'b11;
        isLong  = sizCode == 2'b00 || isLine;
        acks    = errAck ? 1 : (wordPort && isLong) ? 2 : isLine ? 4 : 1;
        wr      = randBits(32);
        taBase  = taCount;
        teaBase = teaCount;
        tsBase  = tsCount;
        testsRun++;
        siz       = sizCode;
        a         = addr;
        rnw       = read;
        tt        = 2'b00;
        nTci      = !ciLow;
        nTbi      = !biLow;
        cpuWrData = wr;
        nTsCpu = 1'b0;
        waitCycles(1);
        nTsCpu = 1'b1;
        while (nTsPort) waitCycles(1); // Watchdog bounds this
        assert (portAddr == addr) else reportError($sformatf("portAddr %0d", portAddr));
        if (!read) begin
            mask = wrMask(sizCode, addr, wordPort);
            want = wrExpect(sizCode, addr, wordPort, 1'b0, wr);
            assert ((portWrData & mask) == (want & mask))
                else reportError($sformatf("write lanes %h want %h", portWrData, want));
        end
        for (int i = 0; i < acks; i++) begin
            w = 1 + randBits(2); // Wait 1 to 4 cycles
            waitCycles(w - 1);
            words[i]   = 32'hA1B2_C3D4 + ackSeq * 32'h0101_0101;
            ackSeq++;
            portRdData = words[i];
            dsack      = wordPort ? `BS_ACK_WORD : `BS_ACK_LONG;
            nTea       = !errAck;
            if (extraTs && i == acks - 1) begin
                nTsCpu = 1'b0; // Held over the last acknowledge and the termination
            end
            waitCycles(1); // Acknowledge edge
            dsack      = `BS_ACK_NONE;
            nTea       = 1'b1;
            portRdData = '0;
            waitCycles(1); // One edge after it
            nTsCpu = 1'b1;
            term = (i == acks - 1) || (isLine && !wordPort);
            if (!term) begin
                // Second half of a long on a 16-bit port
                assert (!nTsPort && nTa) else reportError("second port start missing");
                assert (portAddr[1]) else reportError("second start without A1");
                if (!read) begin
                    want = wrExpect(sizCode, addr, 1'b1, 1'b1, wr);
                    assert (portWrData[31:16] == want[31:16])
                        else reportError($sformatf("second write %h", portWrData));
                end
            end else if (errAck) begin
                assert (!nTeaCpu && nTa) else reportError("no nTeaCpu on port error");
            end else begin
                assert (!nTa) else reportError("nTa not one cycle after acknowledge");
                assert (nTbiCpu == !(biLow || (isLine && wordPort)))
                    else reportError($sformatf("nTbiCpu %b", nTbiCpu));
                assert (nTciCpu == !ciLow) else reportError($sformatf("nTciCpu %b", nTciCpu));
                if (read) begin
                    mask = opMask(sizCode, addr);
                    want = (isLine && !wordPort) ? words[i] :
                           expRead(sizCode, addr, wordPort, words[0], words[1]);
                    assert ((cpuRdData & mask) == (want & mask))
                        else reportError($sformatf("read %h want %h", cpuRdData, want));
                end
            end
        end
        waitCycles(3); // Let counters see the last pulse
        assert (taCount - taBase == (errAck ? 0 : (isLine && !wordPort) ? 4 : 1))
            else reportError($sformatf("%0d nTa pulses", taCount - taBase));
        assert (teaCount - teaBase == (errAck ? 1 : 0))
            else reportError($sformatf("%0d nTeaCpu pulses", teaCount - teaBase));
        assert (tsCount - tsBase == ((wordPort && isLong && !errAck) ? 2 : 1))
            else reportError($sformatf("%0d port starts", tsCount - tsBase));
    endtask

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    initial begin
        nRESET     = 1'b0;
        nTsCpu     = 1'b1;
        siz        = 2'b00;
        a          = 2'b00;
        tt         = 2'b00;
        rnw        = 1'b1;
        nTbi       = 1'b1;
        nTci       = 1'b1;
        cpuWrData  = '0;
        dsack      = `BS_ACK_NONE;
        nTea       = 1'b1;
        portRdData = '0;
        waitCycles(2);
        nRESET = 1'b1;
        assert (nTa && nTeaCpu && nTbiCpu && nTciCpu && nTsPort && cpuRdData == '0)
            else reportError("strobes or data not idle after reset");
        runCycle(2'b00, 2'd0, 1, 0, 0, 0, 0, 0); // Long on a 32-bit port
        runCycle(2'b00, 2'd0, 0, 0, 0, 0, 0, 0);
        runCycle(2'b00, 2'd0, 1, 1, 0, 0, 0, 0); // Long on a 16-bit port
        runCycle(2'b00, 2'd0, 0, 1, 0, 0, 0, 0);
        for (int p = 0; p < 2; p++) begin
            for (int r = 0; r < 2; r++) begin
                runCycle(2'b10, 2'd0, r[0], p[0], 0, 0, 0, 0); // Words
                runCycle(2'b10, 2'd2, r[0], p[0], 0, 0, 0, 0);
                for (int ad = 0; ad < 4; ad++) begin
                    runCycle(2'b01, ad[1:0], r[0], p[0], 0, 0, 0, 0); // Bytes
                end
            end
        end
        runCycle(2'b11, 2'd0, 1, 0, 0, 0, 0, 0); // Line bursts
        runCycle(2'b11, 2'd0, 1, 1, 0, 0, 0, 0); // Line cut to one long
        runCycle(2'b00, 2'd0, 1, 0, 1, 0, 0, 0); // Port errors
        runCycle(2'b00, 2'd0, 1, 1, 1, 0, 0, 0);
        runCycle(2'b00, 2'd0, 1, 0, 0, 1, 0, 0); // Cache inhibit
        runCycle(2'b00, 2'd0, 1, 0, 0, 0, 1, 0); // Burst inhibit
        runCycle(2'b00, 2'd0, 0, 1, 0, 0, 0, 1); // TS while busy
        if (errors == 0 && testsRun == numTests) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            $display("Only %0d of %0d cycles run", testsRun, numTests);
            $display("RESULT: FAIL");
            $fatal(1, "test run incomplete");
        end
    end

    // Watchdog sized from the test count
    initial begin
        #((2 + numTests * 40) * 10);
        $display("Timeout: the bridge stopped answering");
        $display("RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// ==== logic/busSizerTop.sv ====
// MC68040 dynamic bus sizing bridge
// 32-bit CPU side to a system bus with 32-bit and 16-bit ports

`default_nettype none

module busSizerTop import busSizerPkg::*; (
    input  logic        BCLK,
    input  logic        nRESET,
    // CPU side
    input  logic        nTsCpu,
    input  logic [1:0]  siz,
    input  logic [1:0]  a,
    input  logic [1:0]  tt,
    input  logic        rnw,
    input  logic        nTbi,
    input  logic        nTci,
    input  logic [31:0] cpuWrData,
    output logic [31:0] cpuRdData,
    output logic        nTa,
    output logic        nTbiCpu,
    output logic        nTciCpu,
    output logic        nTeaCpu,
    // Port side
    input  logic [1:0]  dsack,
    input  logic        nTea,
    input  logic [31:0] portRdData,
    output logic        nTsPort,
    output logic [31:0] portWrData,
    output logic [1:0]  portAddr
);

    cycleDesc_t desc;  // Captured CPU cycle
    logic       start; // New cycle for the sequencer
    logic       busy;
    seqPhase_e  phase;
    logic       latch; // Port acknowledge strobe

    ////////////////////////////////////////
    // Blocks
    ////////////////////////////////////////

    cycleDecoder i_cycleDecoder (
        .BCLK   (BCLK),
        .nRESET (nRESET),
        .nTsCpu (nTsCpu),
        .siz    (siz),
        .a      (a),
        .tt     (tt),
        .rnw    (rnw),
        .nTci   (nTci),
        .nTbi   (nTbi),
        .busy   (busy),
        .desc   (desc),
        .start  (start)
    );

    laneSteer i_laneSteer (
        .BCLK       (BCLK),
        .nRESET     (nRESET),
        .desc       (desc),
        .phase      (phase),
        .latch      (latch),
        .dsack      (dsack),
        .cpuWrData  (cpuWrData),
        .portRdData (portRdData),
        .portWrData (portWrData),
        .cpuRdData  (cpuRdData)
    );

    sizeSequencer i_sizeSequencer (
        .BCLK     (BCLK),
        .nRESET   (nRESET),
        .desc     (desc),
        .start    (start),
        .dsack    (dsack),
        .nTea     (nTea),
        .phase    (phase),
        .latch    (latch),
        .busy     (busy),
        .nTsPort  (nTsPort),
        .nTa      (nTa),
        .nTbiCpu  (nTbiCpu),
        .nTciCpu  (nTciCpu),
        .nTeaCpu  (nTeaCpu),
        .portAddr (portAddr)
    );

endmodule

`default_nettype wire

// ==== logic/sizeSequencer.sv ====
// Size sequencer
// Runs one or two port cycles per CPU cycle from DSACK, counts line beats
// and generates the one-cycle CPU termination strobes

`default_nettype none

`include "busSizer_cfg.svh"

module sizeSequencer import busSizerPkg::*; (
    input  logic       BCLK,
    input  logic       nRESET,
    input  cycleDesc_t desc,
    input  logic       start,
    input  logic [1:0] dsack,
    input  logic       nTea,
    output seqPhase_e  phase,
    output logic       latch,
    output logic       busy,
    output logic       nTsPort,
    output logic       nTa,
    output logic       nTbiCpu,
    output logic       nTciCpu,
    output logic       nTeaCpu,
    output logic [1:0] portAddr
);

    localparam int beatW = $clog2(`BS_BURST_BEATS);
    localparam logic [beatW-1:0] lastBeat = beatW'(`BS_BURST_BEATS - 1);

    logic             issue;      // Port TS goes out next edge
    logic             secondHalf; // A1 forced high for the second port cycle
    logic [beatW-1:0] beatCnt;    // Line beats acknowledged
    logic             termPend;   // Terminate the CPU next edge
    logic             termErr;
    logic             termTbi;
    logic             termTci;

    logic ack;      // Valid DSACK this edge
    logic wordAck;  // Port is 16 bits
    logic wide;     // Long or line
    logic burstOk;  // Line allowed to burst
    logic goSecond; // Fetch the other half
    logic goBeat;   // Line continues with beats
    logic lastAck;  // Final beat of the line
    logic termNow;

    ////////////////////////////////////////
    // Acknowledge decode
    ////////////////////////////////////////

    assign ack      = (phase != phIdle) && !issue && (dsack != `BS_ACK_NONE);
    assign wordAck  = dsack == `BS_ACK_WORD;
    assign wide     = (desc.size == szLong) || (desc.size == szLine);
    assign burstOk  = desc.lineBurst && !desc.biReq;
    assign goSecond = ack && (phase == phFirst) && wordAck && wide && nTea;
    assign goBeat   = ack && (phase == phFirst) && !wordAck && burstOk && nTea;
    assign lastAck  = beatCnt == lastBeat;
    assign termNow  = ack && !goSecond; // Every other acknowledge ends a CPU transfer

    assign latch    = ack;
    assign busy     = (phase != phIdle) || start || termPend;
    assign portAddr = {desc.addr[1] | secondHalf, desc.addr[0]};

    ////////////////////////////////////////
    // Phase FSM
    ////////////////////////////////////////

    always_ff @(posedge BCLK or negedge nRESET) begin
        if (!nRESET) begin
            phase      <= phIdle;
            issue      <= 1'b0;
            secondHalf <= 1'b0;
            beatCnt    <= '0;
        end else begin
            issue <= 1'b0;
            case (phase)
                phIdle: begin
                    if (start) begin
                        phase      <= phFirst;
                        issue      <= 1'b1;
                        secondHalf <= 1'b0;
                        beatCnt    <= '0;
                    end
                end
                phFirst: begin
                    if (goSecond) begin
                        phase      <= phSecond; // Same CPU cycle, next word
                        issue      <= 1'b1;
                        secondHalf <= 1'b1;
                    end else if (goBeat) begin
                        phase   <= phBeat; // Port keeps the one TS
                        beatCnt <= beatW'(1);
                    end else if (ack) begin
                        phase <= phIdle;
                    end
                end
                phSecond: begin
                    if (ack) phase <= phIdle;
                end
                default: begin // phBeat
                    if (ack) begin
                        beatCnt <= beatCnt + 1'b1;
                        if (lastAck || !nTea || wordAck) begin
                            phase <= phIdle; // Line done or cut short
                        end
                    end
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // Strobes
    ////////////////////////////////////////

    // Flags captured with the acknowledge, pins one edge later
    always_ff @(posedge BCLK or negedge nRESET) begin
        if (!nRESET) begin
            termPend <= 1'b0;
            termErr  <= 1'b0;
            termTbi  <= 1'b0;
            termTci  <= 1'b0;
            nTsPort  <= 1'b1;
            nTa      <= 1'b1;
            nTeaCpu  <= 1'b1;
            nTbiCpu  <= 1'b1;
            nTciCpu  <= 1'b1;
        end else begin
            termPend <= termNow;
            termErr  <= !nTea;
            // Line that cannot burst, or one acked by a 16-bit port
            termTbi  <= desc.biReq || (desc.size == szLine && !(burstOk && !wordAck));
            termTci  <= desc.ciReq;
            nTsPort  <= !issue;
            nTa      <= !(termPend && !termErr);
            nTeaCpu  <= !(termPend && termErr); // Error replaces TA
            nTbiCpu  <= !(termPend && termTbi && !termErr);
            nTciCpu  <= !(termPend && termTci);
        end
    end

endmodule

`default_nettype wire

// ==== logic/laneSteer.sv ====
// Lane steering data buffer
// Copies write bytes onto the port lanes a narrow port expects,
// assembles read data from one or two port cycles for the CPU

`default_nettype none

`include "busSizer_cfg.svh"

module laneSteer import busSizerPkg::*; (
    input  logic       BCLK,
    input  logic       nRESET,
    input  cycleDesc_t desc,
    input  seqPhase_e  phase,
    input  logic       latch,      // Port acknowledge this edge
    input  logic [1:0] dsack,
    input  busWord_u   cpuWrData,
    input  busWord_u   portRdData,
    output busWord_u   portWrData,
    output busWord_u   cpuRdData
);

    busWord_u rdHold;   // Read word being assembled
    logic     rdLatch;  // Acknowledge of a read cycle
    logic     latchD;   // Hand assembled word to CPU side
    logic     wide;     // Long or line
    logic     halfSel;  // Half a 16-bit port fills

    assign wide = (desc.size == szLong) || (desc.size == szLine);

    // Second phase carries the low word, small operands follow A1
    assign halfSel = (phase == phSecond) || (!wide && desc.addr[1]);

    assign rdLatch = latch && desc.read;

    ////////////////////////////////////////
    // Write lanes
    ////////////////////////////////////////

    always_comb begin
        portWrData = cpuWrData; // Straight through unless a copy is needed
        if (phase == phSecond) begin
            portWrData.half[0] = cpuWrData.half[1]; // Bytes 2-3 onto lanes 0-1
        end else if (desc.size == szWord && desc.addr[1]) begin
            portWrData.half[0] = cpuWrData.half[1]; // Word at 2 on both halves
        end else if (desc.size == szByte) begin
            // Lane 0 for a 16-bit port, own lane stays for a 32-bit port
            portWrData.lane[0] = cpuWrData.lane[desc.addr];
            if (desc.addr == 2'd3) begin
                portWrData.lane[1] = cpuWrData.lane[3]; // Odd lane of the low half
            end
        end
    end

    ////////////////////////////////////////
    // Read latch
    ////////////////////////////////////////

    // Two stages so a following beat cannot overwrite the word
    // before the CPU samples its TA
    always_ff @(posedge BCLK or negedge nRESET) begin
        if (!nRESET) begin
            rdHold    <= '0;
            latchD    <= 1'b0;
            cpuRdData <= '0;
        end else begin
            latchD <= rdLatch;
            if (rdLatch) begin
                if (dsack == `BS_ACK_WORD) begin
                    // 16-bit port drives lanes 0-1 only
                    rdHold.half[halfSel] <= portRdData.half[0];
                end else begin
                    for (int i = 0; i < 4; i++) begin
                        rdHold.lane[i] <= portRdData.lane[i]; // All lanes straight
                    end
                end
            end
            if (latchD) begin
                cpuRdData <= rdHold; // Valid from the TA edge on
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/cycleDecoder.sv ====
// Cycle decoder
// Captures a CPU transfer start with size, address and type,
// and pulses start to the sequencer for one cycle

`default_nettype none

module cycleDecoder import busSizerPkg::*; (
    input  logic       BCLK,
    input  logic       nRESET,
    input  logic       nTsCpu, // CPU transfer start
    input  logic [1:0] siz,
    input  logic [1:0] a,
    input  logic [1:0] tt,
    input  logic       rnw,
    input  logic       nTci,
    input  logic       nTbi,
    input  logic       busy,   // Sequencer owns the bus
    output cycleDesc_t desc,
    output logic       start
);

    xferSize_e  sizeDec;  // SIZ pins decoded
    cycleDesc_t descNext;
    logic       take;     // TS accepted this edge

    ////////////////////////////////////////
    // Decode
    ////////////////////////////////////////

    // 68040 encoding: 00 long, 01 byte, 10 word, 11 line
    always_comb begin
        case (siz)
            2'b00:   sizeDec = szLong;
            2'b01:   sizeDec = szByte;
            2'b10:   sizeDec = szWord;
            default: sizeDec = szLine;
        endcase
    end

    always_comb begin
        descNext.size      = sizeDec;
        descNext.addr      = a;
        descNext.read      = rnw;
        // Normal and MOVE16 accesses may burst, TT1 set never does
        descNext.lineBurst = (sizeDec == szLine) && !tt[1];
        descNext.ciReq     = !nTci;
        descNext.biReq     = !nTbi;
    end

    // TS while a cycle is running is dropped
    assign take = !nTsCpu && !busy;

    ////////////////////////////////////////
    // Capture
    ////////////////////////////////////////

    always_ff @(posedge BCLK or negedge nRESET) begin
        if (!nRESET) begin
            desc  <= '0;
            start <= 1'b0;
        end else begin
            start <= take; // One cycle, busy blocks a repeat
            if (take) begin
                desc <= descNext; // Held for the whole CPU cycle
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/busSizerPkg.sv ====
// Bus sizing bridge types
// Captured CPU cycle, sequencer phase and the two views of a data word

`default_nettype none

package busSizerPkg;

    ////////////////////////////////////////
    // CPU cycle descriptor
    ////////////////////////////////////////

    // SIZ1:0 decoded, order is not the pin encoding
    typedef enum logic [1:0] {
        szByte = 2'd0,
        szWord = 2'd1,
        szLong = 2'd2,
        szLine = 2'd3
    } xferSize_e;

    // Everything the bridge needs from the TS cycle
    typedef struct packed {
        xferSize_e  size;      // Operand size
        logic [1:0] addr;      // A1:0
        logic       read;      // R/W high at start
        logic       lineBurst; // Line with a burstable TT
        logic       ciReq;     // TCI low at start
        logic       biReq;     // TBI low at start
    } cycleDesc_t;

    ////////////////////////////////////////
    // Sequencer phase
    ////////////////////////////////////////

    // Also tells the steering which half of a long word is on the bus
    typedef enum logic [1:0] {
        phIdle   = 2'd0, // No cycle
        phFirst  = 2'd1, // First port cycle
        phSecond = 2'd2, // Low word of a long on a 16-bit port
        phBeat   = 2'd3  // Remaining line beats on a 32-bit port
    } seqPhase_e;

    ////////////////////////////////////////
    // Data word
    ////////////////////////////////////////

    // Byte view for 32-bit ports, half view for 16-bit ports
    // Index 0 is the most significant in both views
    typedef union packed {
        logic [0:3][7:0]  lane; // lane 0 = D31:24
        logic [0:1][15:0] half; // half 0 = D31:16
    } busWord_u;

endpackage

`default_nettype wire

// ==== include/busSizer_cfg.svh ====
// Bus sizing bridge configuration
// Line transfer length and the DSACK codes used for port width

`ifndef BUSSIZER_CFG_SVH
`define BUSSIZER_CFG_SVH

////////////////////////////////////////
// Line transfers
////////////////////////////////////////

// Long words in one cache line burst
`define BS_BURST_BEATS 4

////////////////////////////////////////
// DSACK1:0 codes, active low
////////////////////////////////////////

`define BS_ACK_LONG 2'b00 // 32-bit port
`define BS_ACK_WORD 2'b01 // 16-bit port
`define BS_ACK_NONE 2'b11 // Still waiting

// Byte port code 10 is not decoded here
`endif
